//--- Bender.yml
package:
  name: agc_monitor

sources:
  - files:
      - hdl/monitor_pkg.sv
      - hdl/cmd_controller.sv
      - hdl/control_regs.sv
      - hdl/status_regs.sv
      - hdl/start_stop.sv
      - hdl/monitor.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/monitor_tb.sv

//--- hdl/cmd_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_controller (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire monitor_pkg::cmd_t  cmd,
    input  wire                  cmd_ready,
    input  wire monitor_pkg::word_t read_data,
    output logic                 cmd_read_en,
    output monitor_pkg::addr_t   reg_addr,
    output monitor_pkg::word_t   reg_data,
    output logic                 ctrl_read_en,
    output logic                 ctrl_write_en,
    output logic                 status_read_en,
    output logic                 status_write_en,
    output monitor_pkg::msg_t    read_msg,
    output logic                 read_msg_ready
);
    import monitor_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        CAPTURE,
        RESPOND
    } state_t;

    state_t state;
    state_t state_next;
    cmd_t   cmd_q;
    logic   issue;
    logic   is_ctrl;
    logic   is_status;

    // Pop a command only while idle
    assign cmd_read_en = (state == IDLE) && cmd_ready;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (cmd_ready) state_next = ISSUE;
            ISSUE:   state_next = cmd_q.write ? IDLE : CAPTURE;
            CAPTURE: state_next = RESPOND;
            RESPOND: state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_read_en) begin
            cmd_q <= cmd;
        end
    end

    assign reg_addr = cmd_q.addr;
    assign reg_data = cmd_q.data;

    // Unknown groups get no strobe
    assign issue     = (state == ISSUE);
    assign is_ctrl   = (cmd_q.group == GROUP_CTRL);
    assign is_status = (cmd_q.group == GROUP_STATUS);

    assign ctrl_read_en    = issue && is_ctrl && !cmd_q.write;
    assign ctrl_write_en   = issue && is_ctrl && cmd_q.write;
    assign status_read_en  = issue && is_status && !cmd_q.write;
    assign status_write_en = issue && is_status && cmd_q.write;

    // Register data arrives the cycle after the strobe
    always_ff @(posedge clk) begin
        if (state == CAPTURE) begin
            read_msg.write <= 1'b0;
            read_msg.group <= cmd_q.group;
            read_msg.addr  <= cmd_q.addr;
            read_msg.data  <= read_data;
        end
    end

    assign read_msg_ready = (state == RESPOND);

endmodule

`default_nettype wire

//--- hdl/control_regs.sv
`timescale 1ns/1ps
`default_nettype none

module control_regs (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire monitor_pkg::addr_t       addr,
    input  wire monitor_pkg::word_t       data_in,
    input  wire                         read_en,
    input  wire                         write_en,
    input  wire monitor_pkg::stop_conds_t stop_cause,
    output monitor_pkg::word_t          data_out,
    output logic                        start_req,
    output logic                        proceed_req,
    output monitor_pkg::stop_conds_t    stop_conds,
    output monitor_pkg::inhibits_t      inhibits
);
    import monitor_pkg::*;

    // Writes and request pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_req   <= 1'b0;
            proceed_req <= 1'b0;
            stop_conds  <= '0;
            inhibits    <= '0;
        end else begin
            start_req   <= write_en && (addr == CTRL_START);
            proceed_req <= write_en && (addr == CTRL_PROCEED);
            if (write_en) begin
                case (addr)
                    CTRL_STOP_CONDS: stop_conds <= data_in[2:0];
                    CTRL_INHIBITS:   inhibits   <= data_in[6:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data is held for one cycle only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (read_en) begin
            case (addr)
                CTRL_STOP_CONDS: data_out <= {13'd0, stop_conds};
                CTRL_STOP_CAUSE: data_out <= {13'd0, stop_cause};
                CTRL_INHIBITS:   data_out <= {9'd0, inhibits};
                default:         data_out <= '0;
            endcase
        end else begin
            data_out <= '0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/monitor.sv
`timescale 1ns/1ps
`default_nettype none

module monitor (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire monitor_pkg::cmd_t    cmd,
    input  wire                     cmd_ready,
    input  wire monitor_pkg::alarms_t alarms,
    input  wire                     mnisq,
    input  wire                     mgojam,
    output logic                    cmd_read_en,
    output monitor_pkg::msg_t       read_msg,
    output logic                    read_msg_ready,
    output monitor_pkg::inhibits_t  inhibits,
    output logic                    mstrt,
    output logic                    mstp
);
    import monitor_pkg::*;

    addr_t       reg_addr;
    word_t       reg_data;
    logic        ctrl_read_en;
    logic        ctrl_write_en;
    logic        status_read_en;
    logic        status_write_en;
    word_t       ctrl_data;
    word_t       status_data;
    word_t       read_data;
    logic        start_req;
    logic        proceed_req;
    stop_conds_t stop_conds;
    stop_conds_t stop_cause;

    // Idle blocks return zero
    assign read_data = ctrl_data | status_data;

    cmd_controller u_cmd_controller (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd             (cmd),
        .cmd_ready       (cmd_ready),
        .read_data       (read_data),
        .cmd_read_en     (cmd_read_en),
        .reg_addr        (reg_addr),
        .reg_data        (reg_data),
        .ctrl_read_en    (ctrl_read_en),
        .ctrl_write_en   (ctrl_write_en),
        .status_read_en  (status_read_en),
        .status_write_en (status_write_en),
        .read_msg        (read_msg),
        .read_msg_ready  (read_msg_ready)
    );

    control_regs u_control_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .addr        (reg_addr),
        .data_in     (reg_data),
        .read_en     (ctrl_read_en),
        .write_en    (ctrl_write_en),
        .stop_cause  (stop_cause),
        .data_out    (ctrl_data),
        .start_req   (start_req),
        .proceed_req (proceed_req),
        .stop_conds  (stop_conds),
        .inhibits    (inhibits)
    );

    status_regs u_status_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (reg_addr),
        .data_in  (reg_data),
        .read_en  (status_read_en),
        .write_en (status_write_en),
        .alarms   (alarms),
        .data_out (status_data)
    );

    // Parity alarm doubles as a stop condition
    start_stop u_start_stop (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_req   (start_req),
        .proceed_req (proceed_req),
        .stop_conds  (stop_conds),
        .mnisq       (mnisq),
        .mgojam      (mgojam),
        .mpal_n      (alarms.mpal_n),
        .stop_cause  (stop_cause),
        .mstrt       (mstrt),
        .mstp        (mstp)
    );

endmodule

`default_nettype wire

//--- hdl/monitor_pkg.sv
`default_nettype none

package monitor_pkg;

    // AGC data word, register address and group selector
    typedef logic [15:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [6:0]  group_t;

    // 40-bit host command word
    typedef struct packed {
        logic   write;
        group_t group;
        addr_t  addr;
        word_t  data;
    } cmd_t;

    // Read response uses the command layout with write cleared
    typedef struct packed {
        logic   write;
        group_t group;
        addr_t  addr;
        word_t  data;
    } msg_t;

    // Active-low alarm inputs from the AGC
    typedef struct packed {
        logic mvfail_n;
        logic moscal_n;
        logic mscafl_n;
        logic mscdbl_n;
        logic mctral_n;
        logic mtcal_n;
        logic mrptal_n;
        logic mpal_n;
        logic mwatch_n;
        logic mpipal_n;
        logic mwarnf_n;
    } alarms_t;

    localparam int NUM_ALARMS = $bits(alarms_t);

    // Inhibit and test lines to the AGC
    typedef struct packed {
        logic mnhrpt;
        logic mnhnc;
        logic nhalga;
        logic nhstrt1;
        logic nhstrt2;
        logic doscal;
        logic dbltst;
    } inhibits_t;

    // Stop condition bits shared by enables and cause
    typedef logic [2:0] stop_conds_t;

    localparam int STOP_INSTR  = 0;
    localparam int STOP_GOJAM  = 1;
    localparam int STOP_PARITY = 2;

    localparam group_t GROUP_CTRL   = 7'h20;
    localparam group_t GROUP_STATUS = 7'h21;

    localparam addr_t CTRL_START      = 16'd0;
    localparam addr_t CTRL_PROCEED    = 16'd1;
    localparam addr_t CTRL_STOP_CONDS = 16'd2;
    localparam addr_t CTRL_STOP_CAUSE = 16'd3;
    localparam addr_t CTRL_INHIBITS   = 16'd4;

    localparam addr_t STAT_ALARMS = 16'd0;
    localparam addr_t STAT_LIVE   = 16'd1;

endpackage

`default_nettype wire

//--- hdl/start_stop.sv
`timescale 1ns/1ps
`default_nettype none

module start_stop (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         start_req,
    input  wire                         proceed_req,
    input  wire monitor_pkg::stop_conds_t stop_conds,
    input  wire                         mnisq,
    input  wire                         mgojam,
    input  wire                         mpal_n,
    output monitor_pkg::stop_conds_t    stop_cause,
    output logic                        mstrt,
    output logic                        mstp
);
    import monitor_pkg::*;

    stop_conds_t active;
    stop_conds_t hit;

    always_comb begin
        active              = '0;
        active[STOP_INSTR]  = mnisq;
        active[STOP_GOJAM]  = mgojam;
        active[STOP_PARITY] = ~mpal_n;
    end

    assign hit = active & stop_conds;

    // Causes accumulate until a proceed; proceed wins for its cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stop_cause <= '0;
            mstrt      <= 1'b0;
        end else begin
            mstrt <= start_req;
            if (proceed_req) begin
                stop_cause <= '0;
            end else begin
                stop_cause <= stop_cause | hit;
            end
        end
    end

    // AGC held stopped while any cause is latched
    assign mstp = |stop_cause;

endmodule

`default_nettype wire

//--- hdl/status_regs.sv
`timescale 1ns/1ps
`default_nettype none

module status_regs (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire monitor_pkg::addr_t   addr,
    input  wire monitor_pkg::word_t   data_in,
    input  wire                     read_en,
    input  wire                     write_en,
    input  wire monitor_pkg::alarms_t alarms,
    output monitor_pkg::word_t      data_out
);
    import monitor_pkg::*;

    logic [NUM_ALARMS-1:0] latched;
    logic [NUM_ALARMS-1:0] active;
    logic [NUM_ALARMS-1:0] clear_mask;

    // Alarm inputs are active low
    assign active = ~alarms;

    assign clear_mask = (write_en && (addr == STAT_ALARMS)) ?
                        data_in[NUM_ALARMS-1:0] : '0;

    // A new alarm beats the clear on the sticky latches
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            latched <= '0;
        end else begin
            latched <= (latched & ~clear_mask) | active;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_out <= '0;
        end else if (read_en) begin
            case (addr)
                STAT_ALARMS: data_out <= {5'd0, latched};
                STAT_LIVE:   data_out <= {5'd0, active};
                default:     data_out <= '0;
            endcase
        end else begin
            data_out <= '0;
        end
    end

endmodule

`default_nettype wire

//--- project.f
hdl/monitor_pkg.sv
hdl/cmd_controller.sv
hdl/control_regs.sv
hdl/status_regs.sv
hdl/start_stop.sv
hdl/monitor.sv
tb/tb_clock.sv
tb/monitor_tb.sv

//--- tb/monitor_golden.txt
# Columns by keyword, all values hex
# pins <alarms> <mnisq> <mgojam> / write <group> <addr> <data>
# read <group> <addr> <expected data> / expect <mstp> <inhibits> / idle <cycles>
idle 2
expect 0 00
read 20 2 0000
# Inhibit round trip and unknown group
write 20 4 0055
read 20 4 0055
expect 0 55
read 7f 0 0000
write 20 0 0000
# GOJAM stop, then proceed
write 20 2 0002
pins 7ff 0 1
pins 7ff 0 0
expect 1 55
read 20 3 0002
write 20 1 0000
expect 0 55
read 20 3 0000
# Parity stop
write 20 2 0004
pins 7f7 0 0
pins 7ff 0 0
expect 1 55
read 20 3 0004
write 20 1 0000
write 21 0 07ff
read 21 0 0000
# mvfail_n and mwatch_n pulse
pins 3fb 0 0
pins 7ff 0 0
read 21 0 0404
read 21 1 0000
write 21 0 0400
read 21 0 0004

//--- tb/monitor_tb.sv
`timescale 1ns/1ps
`default_nettype none

module monitor_tb;
    import monitor_pkg::*;

    logic      clk;
    logic      rst_n;
    cmd_t      cmd;
    logic      cmd_ready;
    alarms_t   alarms;
    logic      mnisq;
    logic      mgojam;
    logic      cmd_read_en;
    msg_t      read_msg;
    logic      read_msg_ready;
    inhibits_t inhibits;
    logic      mstrt;
    logic      mstp;

    tb_clock u_tb_clock (
        .clk (clk)
    );

    monitor u_monitor (
        .clk            (clk),
        .rst_n          (rst_n),
        .cmd            (cmd),
        .cmd_ready      (cmd_ready),
        .alarms         (alarms),
        .mnisq          (mnisq),
        .mgojam         (mgojam),
        .cmd_read_en    (cmd_read_en),
        .read_msg       (read_msg),
        .read_msg_ready (read_msg_ready),
        .inhibits       (inhibits),
        .mstrt          (mstrt),
        .mstp           (mstp)
    );

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        abort_run();
    endtask

    task automatic check_msg(input msg_t got, input msg_t exp);
        if (got !== exp) begin
            $display("error: %0d ns: read_msg is %b/%h/%h/%h, expected %b/%h/%h/%h",
                     $time, got.write, got.group, got.addr, got.data,
                     exp.write, exp.group, exp.addr, exp.data);
            abort_run();
        end
    endtask

    task automatic check_inhibits(input inhibits_t got, input inhibits_t exp);
        if (got !== exp) begin
            $display("error: %0d ns: inhibits is %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error: %0d ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic drive_pins(input alarms_t a, input logic nisq, input logic gojam);
        @(posedge clk);
        #1;
        alarms = a;
        mnisq  = nisq;
        mgojam = gojam;
    endtask

    task automatic expect_levels(input logic exp_mstp, input inhibits_t exp_inh);
        @(negedge clk);
        check_bit(mstp, exp_mstp, "mstp");
        // mstrt only pulses inside a start write
        check_bit(mstrt, 1'b0, "mstrt");
        check_inhibits(inhibits, exp_inh);
    endtask

    // Data is the write value, or the expected read data
    task automatic issue_command(input cmd_t c, input word_t exp_data);
        msg_t exp_msg;
        logic is_start;
        logic seen;
        int   waited;
        @(posedge clk);
        #1;
        cmd       = c;
        cmd_ready = 1'b1;
        seen      = 1'b0;
        waited    = 0;
        while (!seen && waited < 16) begin
            @(negedge clk);
            seen = cmd_read_en;
            waited++;
        end
        if (!seen) begin
            report_timeout("cmd_read_en");
        end
        @(posedge clk);
        #1;
        cmd_ready = 1'b0;
        cmd       = '0;
        if (c.write) begin
            // Start pulse lands 3 cycles after the pop
            is_start = (c.group == GROUP_CTRL) && (c.addr == CTRL_START);
            for (int cyc = 1; cyc <= 4; cyc++) begin
                @(negedge clk);
                check_bit(mstrt, is_start && (cyc == 3), "mstrt");
            end
        end else begin
            seen   = 1'b0;
            waited = 0;
            while (!seen && waited < 16) begin
                @(negedge clk);
                seen = read_msg_ready;
                waited++;
            end
            if (!seen) begin
                report_timeout("read_msg_ready");
            end
            exp_msg.write = 1'b0;
            exp_msg.group = c.group;
            exp_msg.addr  = c.addr;
            exp_msg.data  = exp_data;
            check_msg(read_msg, exp_msg);
        end
    endtask

    task automatic run_golden();
        int              fd;
        int              n;
        logic [8*96-1:0] text_line;
        logic [63:0]     kw;
        logic [31:0]     f1;
        logic [31:0]     f2;
        logic [31:0]     f3;
        cmd_t            c;
        fd = $fopen("tb/monitor_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open tb/monitor_golden.txt");
            abort_run();
        end
        while ($fgets(text_line, fd) > 0) begin
            kw = '0;
            n  = $sscanf(text_line, "%s %h %h %h", kw, f1, f2, f3);
            if (n < 1 || kw == "#") begin
                continue;
            end
            if (kw == "pins" && n == 4) begin
                drive_pins(f1[10:0], f2[0], f3[0]);
            end else if ((kw == "write" || kw == "read") && n == 4) begin
                c.write = (kw == "write");
                c.group = f1[6:0];
                c.addr  = f2[15:0];
                c.data  = c.write ? f3[15:0] : 16'h0000;
                issue_command(c, f3[15:0]);
            end else if (kw == "expect" && n == 3) begin
                expect_levels(f1[0], f2[6:0]);
            end else if (kw == "idle" && n == 2) begin
                repeat (f1) @(posedge clk);
            end else begin
                $display("Unreadable line in the golden file: %0s", text_line);
                abort_run();
            end
        end
        $fclose(fd);
    endtask

    initial begin
        rst_n     = 1'b0;
        cmd       = '0;
        cmd_ready = 1'b0;
        alarms    = '1;
        mnisq     = 1'b0;
        mgojam    = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        run_golden();
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    // Free-running clock with a 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule

`default_nettype wire
